//--- vdc_cfg.svh
//////////////////////////////
// video controller build constants
//////////////////////////////
`ifndef VDC_CFG_SVH
`define VDC_CFG_SVH

`define VDC_ADDR_W   6   // register address bits
`define VDC_DATA_W   8   // host bus and video memory data bits
`define VDC_NREGS    38  // R0 to R37
`define VDC_VRAM_AW  16  // video memory address bits

`define VDC_VB_FRONT 2   // vblank lines ahead of vsync
`define VDC_VB_BACK  2   // vblank lines after vsync ends

`define VDC_LCNT_W   13  // lines since vsync, covers 256 rows of 32 lines

`endif

//--- vdc_pkg.sv
//////////////////////////////
// video controller register map
// and nibble register view
//////////////////////////////
`include "vdc_cfg.svh"

package vdc_pkg;

	// register indices in the R0 to R37 map
	localparam logic [`VDC_ADDR_W-1:0] REG_HT    = 'd0;  // horizontal total
	localparam logic [`VDC_ADDR_W-1:0] REG_HD    = 'd1;  // horizontal displayed
	localparam logic [`VDC_ADDR_W-1:0] REG_HP    = 'd2;  // hsync position
	localparam logic [`VDC_ADDR_W-1:0] REG_SYNCW = 'd3;  // vsync / hsync width
	localparam logic [`VDC_ADDR_W-1:0] REG_VT    = 'd4;  // vertical total in rows
	localparam logic [`VDC_ADDR_W-1:0] REG_VA    = 'd5;  // vertical total adjust
	localparam logic [`VDC_ADDR_W-1:0] REG_VD    = 'd6;  // vertical displayed
	localparam logic [`VDC_ADDR_W-1:0] REG_VP    = 'd7;  // vsync position
	localparam logic [`VDC_ADDR_W-1:0] REG_CTV   = 'd9;  // lines per row minus 1
	localparam logic [`VDC_ADDR_W-1:0] REG_DSH   = 'd12; // display start high
	localparam logic [`VDC_ADDR_W-1:0] REG_DSL   = 'd13; // display start low
	localparam logic [`VDC_ADDR_W-1:0] REG_CHAR  = 'd22; // char total / displayed
	localparam logic [`VDC_ADDR_W-1:0] REG_COLOR = 'd26; // fg / bg rgbi

	// one register byte, seen whole or as two nibbles
	typedef union packed {
		logic [`VDC_DATA_W-1:0] word;
		struct packed {
			logic [`VDC_DATA_W/2-1:0] hi; // R3 vw, R22 cth, R26 fg
			logic [`VDC_DATA_W/2-1:0] lo; // R3 hw, R22 cdh, R26 bg
		} nib;
	} vdc_reg_u;

endpackage

//--- vdc_reg_if.sv
//////////////////////////////
// decoded register fields
//////////////////////////////
`timescale 1ns/1ps
`include "vdc_cfg.svh"

interface vdc_reg_if;
	logic [7:0]              ht;         // columns per line minus 1
	logic [7:0]              hd;         // visible columns
	logic [7:0]              hp;         // hsync start column
	logic [3:0]              hw;         // hsync width in columns
	logic [3:0]              vw;         // vsync width in lines, 0 is 16
	logic [7:0]              vt;         // rows per frame minus 1
	logic [4:0]              va;         // extra lines after last row
	logic [7:0]              vd;         // visible rows
	logic [7:0]              vp;         // vsync start row
	logic [4:0]              ctv;        // lines per row minus 1
	logic [3:0]              cth;        // dots per column minus 1
	logic [`VDC_VRAM_AW-1:0] disp_start; // first bitmap byte
	logic [3:0]              fg;         // rgbi for set bits
	logic [3:0]              bg;         // rgbi for clear bits

	modport ctrl (
		output ht, hd, hp, hw, vw, vt, va, vd, vp, ctv, cth, disp_start, fg, bg
	);

	modport user (
		input ht, hd, hp, hw, vw, vt, va, vd, vp, ctv, cth, disp_start, fg, bg
	);
endinterface

//--- vdc_timing_if.sv
//////////////////////////////
// raster position and strobes
//////////////////////////////
`timescale 1ns/1ps

interface vdc_timing_if;
	logic       new_col;     // first dot of a column
	logic       end_col;     // last dot of a column
	logic [7:0] col;         // column within line
	logic [7:0] row;         // character row within frame
	logic [4:0] line;        // scan line within row
	logic       h_visible;   // column 1 to hd
	logic       v_visible;   // row below vd
	logic       frame_start; // first dot of row 0 line 0

	modport src (
		output new_col, end_col, col, row, line, h_visible, v_visible, frame_start
	);

	modport dst (
		input new_col, end_col, col, row, line, h_visible, v_visible, frame_start
	);
endinterface

//--- vdc_regs.sv
//////////////////////////////
// register file on a wishbone
// classic slave, one wait state
//////////////////////////////
`timescale 1ns/1ps
`include "vdc_cfg.svh"

module vdc_regs (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   wb_cyc,
	input  logic                   wb_stb,
	input  logic                   wb_we,
	input  logic [`VDC_ADDR_W-1:0] wb_adr,
	input  logic [`VDC_DATA_W-1:0] wb_dat_w,
	output logic [`VDC_DATA_W-1:0] wb_dat_r,
	output logic                   wb_ack,
	vdc_reg_if.ctrl                regs
);
	import vdc_pkg::*;

	logic [`VDC_DATA_W-1:0] rf [`VDC_NREGS]; // R0 to R37
	vdc_reg_u               syncw;            // R3
	vdc_reg_u               chr;              // R22
	vdc_reg_u               color;            // R26

	wire hit      = wb_cyc && wb_stb && !wb_ack; // no second ack while stb still high
	wire in_range = wb_adr < `VDC_ADDR_W'(`VDC_NREGS);

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_ack <= 1'b0;
			for (int i = 0; i < `VDC_NREGS; i++)
				rf[i] <= '0;
		end else begin
			wb_ack <= hit;
			if (wb_ack && wb_cyc && wb_we && in_range)
				rf[wb_adr] <= wb_dat_w; // lands in the ack cycle
		end
	end

	// read data is sampled with the request, returned with ack
	always_ff @(posedge clk) begin
		if (hit)
			wb_dat_r <= in_range ? rf[wb_adr] : '0;
	end

	assign syncw.word = rf[REG_SYNCW];
	assign chr.word   = rf[REG_CHAR];
	assign color.word = rf[REG_COLOR];

	assign regs.ht  = rf[REG_HT];
	assign regs.hd  = rf[REG_HD];
	assign regs.hp  = rf[REG_HP];
	assign regs.vw  = syncw.nib.hi;
	assign regs.hw  = syncw.nib.lo;
	assign regs.vt  = rf[REG_VT];
	assign regs.va  = rf[REG_VA][4:0];
	assign regs.vd  = rf[REG_VD];
	assign regs.vp  = rf[REG_VP];
	assign regs.ctv = rf[REG_CTV][4:0];
	assign regs.cth = chr.nib.hi;    // low nibble is text mode only
	assign regs.fg  = color.nib.hi;
	assign regs.bg  = color.nib.lo;

	assign regs.disp_start = {rf[REG_DSH], rf[REG_DSL]};
endmodule

//--- vdc_timing.sv
//////////////////////////////
// raster counters, sync,
// blanking and blink phase
//////////////////////////////
`timescale 1ns/1ps
`include "vdc_cfg.svh"

module vdc_timing (
	input  logic       clk,
	input  logic       rst,
	input  logic       dot_en,
	vdc_reg_if.user    regs,
	vdc_timing_if.src  tim,
	output logic       hsync,
	output logic       vsync,
	output logic       hblank,
	output logic       vblank,
	output logic [1:0] blink
);
	logic [3:0]             pixel;       // dot within column
	logic [7:0]             col;
	logic [7:0]             row;
	logic [4:0]             line;
	logic                   in_adj;      // in the va extra lines
	logic                   new_col;
	logic                   end_col;
	logic                   frame_start;
	logic [3:0]             hs_cnt;      // hsync columns left
	logic [4:0]             vs_cnt;      // vsync lines left
	logic [5:0]             vb_cnt;      // vblank lines left
	logic [`VDC_LCNT_W-1:0] ls_cnt;      // lines since vsync start
	logic [`VDC_LCNT_W-1:0] frame_lines; // lines in last frame
	logic [3:0]             bl16;
	logic [4:0]             bl30;

	// vertical position after the current line
	logic [7:0] row_n;
	logic [4:0] line_n;
	logic       adj_n;
	logic       wrap;

	wire       line_end = dot_en && end_col && col == regs.ht;
	wire [4:0] vs_width = (regs.vw == 4'd0) ? 5'd16 : {1'b0, regs.vw};
	wire       vs_start = line_end && line_n == 5'd0 && row_n == regs.vp && !adj_n;

	// horizontal
	always_ff @(posedge clk) begin
		if (rst) begin
			pixel   <= '0;
			col     <= '0;
			new_col <= 1'b0;
			end_col <= 1'b0;
			hs_cnt  <= '0;
		end else if (dot_en) begin
			new_col <= end_col;                                       // one dot after end_col
			end_col <= (end_col ? 4'd0 : pixel + 4'd1) == regs.cth; // high while pixel == cth
			if (end_col) begin
				pixel <= '0;
				col   <= (col == regs.ht) ? 8'd0 : col + 8'd1;
				if (col == regs.hp - 8'd1)
					hs_cnt <= regs.hw;          // sync from column hp on
				else if (hs_cnt != 4'd0)
					hs_cnt <= hs_cnt - 4'd1;
			end else begin
				pixel <= pixel + 4'd1;
			end
		end
	end

	// next line/row, with the adjust lines after row vt
	always_comb begin
		row_n  = row;
		line_n = line + 5'd1;
		adj_n  = in_adj;
		wrap   = 1'b0;
		if (in_adj) begin
			if (line == regs.va - 5'd1) begin
				row_n  = '0;
				line_n = '0;
				adj_n  = 1'b0;
				wrap   = 1'b1;
			end
		end else if (line == regs.ctv) begin
			line_n = '0;
			if (row != regs.vt) begin
				row_n = row + 8'd1;
			end else if (regs.va == 5'd0) begin
				row_n = '0;
				wrap  = 1'b1;
			end else begin
				row_n = row + 8'd1; // adjust lines count as row vt+1
				adj_n = 1'b1;
			end
		end
	end

	// vertical, vsync and vblank
	always_ff @(posedge clk) begin
		if (rst) begin
			row         <= '0;
			line        <= '0;
			in_adj      <= 1'b0;
			frame_start <= 1'b0;
			vs_cnt      <= '0;
			vb_cnt      <= '0;
			ls_cnt      <= '0;
			frame_lines <= '0;
		end else if (dot_en) begin
			frame_start <= line_end && wrap; // coincides with new_col of col 0
			if (line_end) begin
				row    <= row_n;
				line   <= line_n;
				in_adj <= adj_n;
				if (vs_start)
					vs_cnt <= vs_width;
				else if (vs_cnt != 5'd0)
					vs_cnt <= vs_cnt - 5'd1;
				if (vs_start) begin
					ls_cnt      <= '0;
					frame_lines <= ls_cnt + 1'b1;
					vb_cnt      <= {1'b0, vs_width} + 6'(`VDC_VB_BACK);
				end else begin
					if (ls_cnt != '1)
						ls_cnt <= ls_cnt + 1'b1;
					// front porch, measured on the previous frame
					if (frame_lines != '0 &&
					    ls_cnt + 1'b1 == frame_lines - `VDC_LCNT_W'(`VDC_VB_FRONT))
						vb_cnt <= 6'(`VDC_VB_FRONT);
					else if (vb_cnt != 6'd0)
						vb_cnt <= vb_cnt - 6'd1;
				end
			end
		end
	end

	// blink dividers, once per vsync
	always_ff @(posedge clk) begin
		if (rst) begin
			blink <= '0;
			bl16  <= '0;
			bl30  <= '0;
		end else if (vs_start) begin
			bl16 <= bl16 + 4'd1;
			if (bl16 == 4'd15)
				blink[0] <= ~blink[0];
			if (bl30 == 5'd29) begin
				bl30     <= '0;
				blink[1] <= ~blink[1];
			end else begin
				bl30 <= bl30 + 5'd1;
			end
		end
	end

	assign hsync  = hs_cnt != 4'd0;
	assign hblank = hsync;
	assign vsync  = vs_cnt != 5'd0;
	assign vblank = vb_cnt != 6'd0;

	assign tim.new_col     = new_col;
	assign tim.end_col     = end_col;
	assign tim.col         = col;
	assign tim.row         = row;
	assign tim.line        = line;
	assign tim.h_visible   = col != 8'd0 && col <= regs.hd;
	assign tim.v_visible   = !in_adj && row < regs.vd;
	assign tim.frame_start = frame_start;
endmodule

//--- vdc_pixel.sv
//////////////////////////////
// bitmap fetch and rgbi shifter
//////////////////////////////
`timescale 1ns/1ps
`include "vdc_cfg.svh"

module vdc_pixel (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    dot_en,
	vdc_reg_if.user                 regs,
	vdc_timing_if.dst               tim,
	output logic [`VDC_VRAM_AW-1:0] vram_addr,
	output logic                    vram_rd,
	input  logic [`VDC_DATA_W-1:0]  vram_data,
	output logic [3:0]              rgbi
);
	logic [`VDC_DATA_W-1:0] data_q;  // byte for the next column
	logic [`VDC_DATA_W-1:0] shift_q; // msb is the current dot
	logic                   pend;    // this column fetched a byte
	logic                   show;    // shifter holds visible data

	wire fetch = tim.new_col && tim.h_visible && tim.v_visible;

	always_ff @(posedge clk) begin
		if (rst) begin
			vram_addr <= '0;
			vram_rd   <= 1'b0;
			pend      <= 1'b0;
			show      <= 1'b0;
		end else if (dot_en) begin
			vram_rd <= fetch; // one dot wide
			if (tim.frame_start)
				vram_addr <= regs.disp_start;
			else if (vram_rd)
				vram_addr <= vram_addr + 1'b1; // step once the byte is taken
			if (tim.end_col)
				pend <= tim.h_visible && tim.v_visible;
			// lagging column never wraps into col 0 of the next line
			if (tim.new_col)
				show <= pend && tim.col != 8'd0;
		end
	end

	always_ff @(posedge clk) begin
		if (dot_en) begin
			if (vram_rd)
				data_q <= vram_data; // valid one dot after the request
			if (tim.new_col)
				shift_q <= data_q;
			else
				shift_q <= {shift_q[`VDC_DATA_W-2:0], 1'b0};
		end
	end

	assign rgbi = show ? (shift_q[`VDC_DATA_W-1] ? regs.fg : regs.bg) : 4'd0;
endmodule

//--- vdc_video_top.sv
//////////////////////////////
// video controller top level
//////////////////////////////
`timescale 1ns/1ps
`include "vdc_cfg.svh"

module vdc_video_top (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    dot_en,
	input  logic                    wb_cyc,
	input  logic                    wb_stb,
	input  logic                    wb_we,
	input  logic [`VDC_ADDR_W-1:0]  wb_adr,
	input  logic [`VDC_DATA_W-1:0]  wb_dat_w,
	output logic [`VDC_DATA_W-1:0]  wb_dat_r,
	output logic                    wb_ack,
	output logic [`VDC_VRAM_AW-1:0] vram_addr,
	output logic                    vram_rd,
	input  logic [`VDC_DATA_W-1:0]  vram_data,
	output logic                    hsync,
	output logic                    vsync,
	output logic                    hblank,
	output logic                    vblank,
	output logic [1:0]              blink,
	output logic [3:0]              rgbi
);
	vdc_reg_if    reg_bus ();  // register fields
	vdc_timing_if tim_bus ();  // raster position

	vdc_regs u_regs (
		.clk      (clk),
		.rst      (rst),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.regs     (reg_bus.ctrl)
	);

	vdc_timing u_timing (
		.clk    (clk),
		.rst    (rst),
		.dot_en (dot_en),
		.regs   (reg_bus.user),
		.tim    (tim_bus.src),
		.hsync  (hsync),
		.vsync  (vsync),
		.hblank (hblank),
		.vblank (vblank),
		.blink  (blink)
	);

	vdc_pixel u_pixel (
		.clk       (clk),
		.rst       (rst),
		.dot_en    (dot_en),
		.regs      (reg_bus.user),
		.tim       (tim_bus.dst),
		.vram_addr (vram_addr),
		.vram_rd   (vram_rd),
		.vram_data (vram_data),
		.rgbi      (rgbi)
	);
endmodule

//--- tb_vdc_check.sv
//////////////////////////////
// checker comparing DUT ports
// with the programmed geometry
//////////////////////////////
`timescale 1ns/1ps
`include "vdc_cfg.svh"

module tb_vdc_check (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    dot_en,
	input  logic                    wb_cyc,
	input  logic                    wb_stb,
	input  logic                    wb_we,
	input  logic [`VDC_ADDR_W-1:0]  wb_adr,
	input  logic [`VDC_DATA_W-1:0]  wb_dat_w,
	input  logic [`VDC_DATA_W-1:0]  wb_dat_r,
	input  logic                    wb_ack,
	input  logic [`VDC_VRAM_AW-1:0] vram_addr,
	input  logic                    vram_rd,
	input  logic [`VDC_DATA_W-1:0]  vram_data,
	input  logic                    hsync,
	input  logic                    vsync,
	input  logic                    hblank,
	input  logic                    vblank,
	input  logic [1:0]              blink,
	input  logic [3:0]              rgbi,
	output int                      err_bus,
	output int                      err_sync,
	output int                      err_video,
	output int                      frames
);
	logic [7:0] shadow [64];  // register bytes as the host wrote them
	logic       ack_q = 1'b0;
	logic       rst_q = 1'b0;
	logic       hs_q = 1'b0;
	logic       vs_q = 1'b0;
	logic       vb_q = 1'b0;
	logic       armed = 1'b0; // set from the first vsync on
	int         dots = 0;     // dot enables seen
	int         hs_rise = 0;  // dot of last hsync rise
	int         lines = 0;    // hsync rises seen
	int         vs_line = 0;
	int         vb_line = 0;
	int         reads = 0;    // fetches this frame
	int         line_reads = 0;
	int         dot_idx = 0;  // dot within the byte on screen
	logic [7:0] pix_q [$];    // fetched bytes not yet shown
	logic [3:0] exp_px;

	initial begin
		for (int i = 0; i < 64; i++)
			shadow[i] = 8'h00;
		err_bus   = 0;
		err_sync  = 0;
		err_video = 0;
		frames    = 0;
	end

	function automatic logic [7:0] read_value(input logic [`VDC_ADDR_W-1:0] a);
		return (a < `VDC_NREGS) ? shadow[a] : 8'h00; // unimplemented reads zero
	endfunction

	function automatic int h_period();
		return (shadow[0] + 1) * (shadow[22][7:4] + 1); // (ht+1)*(cth+1)
	endfunction

	function automatic int h_width();
		return shadow[3][3:0] * (shadow[22][7:4] + 1);
	endfunction

	function automatic int v_period();
		return (shadow[4] + 1) * (shadow[9][4:0] + 1) + shadow[5][4:0];
	endfunction

	function automatic int v_width();
		return (shadow[3][7:4] == 4'd0) ? 16 : shadow[3][7:4]; // 0 means 16
	endfunction

	function automatic int frame_reads();
		return shadow[1] * shadow[6] * (shadow[9][4:0] + 1); // hd per visible line
	endfunction

	function automatic logic [3:0] pix_color(input logic [7:0] b, input int d);
		return b[7-d] ? shadow[26][7:4] : shadow[26][3:0]; // msb first, fg or bg
	endfunction

	function automatic logic [1:0] blink_exp(input int n);
		return {1'((n / 30) % 2), 1'((n / 16) % 2)};
	endfunction

	// host bus and reset values on every clk
	always @(posedge clk) begin
		rst_q <= rst;
		ack_q <= wb_ack;
		if (rst && rst_q && (hsync || vsync || hblank || vblank || vram_rd || wb_ack ||
		    rgbi != 4'd0)) begin
			$display("outputs not cleared during reset at %0t", $time);
			err_bus++;
		end
		if (wb_ack && (ack_q || !(wb_cyc && wb_stb))) begin
			$display("ack held over two cycles or given without a request at %0t", $time);
			err_bus++;
		end
		if (wb_ack && wb_cyc && wb_we && wb_adr < `VDC_NREGS)
			shadow[wb_adr] <= wb_dat_w;
		if (wb_ack && wb_cyc && !wb_we && wb_dat_r !== read_value(wb_adr)) begin
			$display("error: wb_dat_r at 0x%h is 0x%h, expected 0x%h",
			         wb_adr, wb_dat_r, read_value(wb_adr));
			err_bus++;
		end
	end

	// raster, fetch and pixels on every dot
	always @(posedge clk) begin
		if (!rst && dot_en) begin
			dots++;
			if (hblank !== hsync) begin
				$display("error: hblank is 0x%h, expected 0x%h", hblank, hsync);
				err_sync++;
			end
			if (vsync && !vblank) begin
				$display("vblank low while vsync is high at %0t", $time);
				err_sync++;
			end
			if (hsync && !hs_q) begin
				if (hs_rise > 0 && dots - hs_rise != h_period()) begin
					$display("error: hsync period 0x%h, expected 0x%h", dots - hs_rise, h_period());
					err_sync++;
				end
				hs_rise = dots;
				lines++;
				if (armed && line_reads != 0 && line_reads != shadow[1]) begin
					$display("error: vram_rd per line 0x%h, expected 0x%h", line_reads, shadow[1]);
					err_video++;
				end
				line_reads = 0;
			end
			if (!hsync && hs_q && dots - hs_rise != h_width()) begin
				$display("error: hsync width 0x%h, expected 0x%h", dots - hs_rise, h_width());
				err_sync++;
			end
			if (vsync && !vs_q) begin
				frames++;
				if (frames > 1 && lines - vs_line != v_period()) begin
					$display("error: vsync period 0x%h, expected 0x%h", lines - vs_line, v_period());
					err_sync++;
				end
				// front porch needs one whole frame measured before it
				if (frames > 2 && lines - vb_line != `VDC_VB_FRONT) begin
					$display("error: vblank lead 0x%h, expected 0x%h", lines - vb_line,
					         `VDC_VB_FRONT);
					err_sync++;
				end
				vs_line = lines;
				if (blink !== blink_exp(frames)) begin
					$display("error: blink is 0x%h, expected 0x%h", blink, blink_exp(frames));
					err_sync++;
				end
				if (armed && (reads != frame_reads() || pix_q.size() != 0)) begin
					$display("error: vram_rd per frame 0x%h, expected 0x%h, 0x%h bytes unshown",
					         reads, frame_reads(), pix_q.size());
					err_video++;
				end
				armed   = 1'b1; // first frame may start from address 0
				reads   = 0;
				dot_idx = 0;
				pix_q.delete();
			end
			if (!vsync && vs_q && lines - vs_line != v_width()) begin
				$display("error: vsync width 0x%h, expected 0x%h", lines - vs_line, v_width());
				err_sync++;
			end
			if (vblank && !vb_q)
				vb_line = lines;
			if (!vblank && vb_q && frames > 2 &&
			    lines - vb_line != v_width() + `VDC_VB_FRONT + `VDC_VB_BACK) begin
				$display("error: vblank width 0x%h, expected 0x%h", lines - vb_line,
				         v_width() + `VDC_VB_FRONT + `VDC_VB_BACK);
				err_sync++;
			end
			if (armed && rgbi != 4'd0) begin
				if (pix_q.size() == 0) begin
					$display("pixels shown with no byte fetched at %0t", $time);
					err_video++;
				end else begin
					exp_px = pix_color(pix_q[0], dot_idx);
					if (rgbi !== exp_px) begin
						$display("error: rgbi is 0x%h, expected 0x%h", rgbi, exp_px);
						err_video++;
					end
					dot_idx++;
					if (dot_idx > shadow[22][7:4]) begin // column done, next byte
						void'(pix_q.pop_front());
						dot_idx = 0;
					end
				end
			end
			if (armed && vram_rd) begin
				if (vram_addr !== 16'({shadow[12], shadow[13]} + reads)) begin
					$display("error: vram_addr is 0x%h, expected 0x%h", vram_addr,
					         16'({shadow[12], shadow[13]} + reads));
					err_video++;
				end
				pix_q.push_back(vram_data); // answer of the memory model
				reads++;
				line_reads++;
			end
			hs_q = hsync;
			vs_q = vsync;
			vb_q = vblank;
		end
	end
endmodule

//--- tb_vdc_video.sv
//////////////////////////////
// testbench for the video
// controller, bus and memory
//////////////////////////////
`timescale 1ns/1ps
`include "vdc_cfg.svh"

module tb_vdc_video;
	import vdc_pkg::*;

	localparam int NFRAMES = 32;  // enough for both blink toggles
	localparam int GEO_HT  = 9;
	localparam int GEO_CTH = 3;
	localparam int GEO_VT  = 5;
	localparam int GEO_CTV = 1;
	localparam int GEO_VA  = 2;
	localparam int FRAME_DOTS = (GEO_HT + 1) * (GEO_CTH + 1) *
	                            ((GEO_VT + 1) * (GEO_CTV + 1) + GEO_VA);
	// up to 4 clk per dot at 4 ns, plus time for the bus phase
	localparam int TIMEOUT_NS = (NFRAMES + 2) * FRAME_DOTS * 4 * 4 + 4000;

	logic                    clk = 1'b0;
	logic                    rst = 1'b1;
	logic                    dot_en = 1'b0;
	logic                    run = 1'b0;   // dots held off while programming
	logic [31:0]             lfsr = 32'h40f1;
	logic                    wb_cyc = 1'b0;
	logic                    wb_stb = 1'b0;
	logic                    wb_we = 1'b0;
	logic [`VDC_ADDR_W-1:0]  wb_adr = '0;
	logic [`VDC_DATA_W-1:0]  wb_dat_w = '0;
	logic [`VDC_DATA_W-1:0]  wb_dat_r;
	logic                    wb_ack;
	logic [`VDC_VRAM_AW-1:0] vram_addr;
	logic                    vram_rd;
	logic [`VDC_DATA_W-1:0]  vram_data = '0;
	logic                    hsync;
	logic                    vsync;
	logic                    hblank;
	logic                    vblank;
	logic [1:0]              blink;
	logic [3:0]              rgbi;
	int                      err_bus;
	int                      err_sync;
	int                      err_video;
	int                      frames;
	int                      bus_fail = 0;

	always #2 clk = ~clk;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
	endfunction

	function automatic logic [7:0] mem_byte(input logic [`VDC_VRAM_AW-1:0] a);
		return (a[7:0] * 8'd37) ^ a[15:8] ^ 8'h96; // every address bit counts
	endfunction

	// dot enable from one lfsr bit, memory answers the open read
	always @(negedge clk) begin
		lfsr = lfsr_step(lfsr);
		dot_en <= run && lfsr[0];
		if (vram_rd)
			vram_data <= mem_byte(vram_addr);
	end

	task automatic wb_cycle(input logic we, input logic [`VDC_ADDR_W-1:0] adr,
	                        input logic [7:0] dat);
		int waited;
		waited = 0;
		@(negedge clk);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = dat;
		while (!wb_ack && waited < 16) begin
			@(negedge clk);
			waited++;
		end
		if (!wb_ack) begin
			$display("no ack from the register port for address %0d", adr);
			bus_fail++;
		end else begin
			@(negedge clk); // hold through the ack cycle so the write lands
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	vdc_video_top i_dut (.*);

	tb_vdc_check i_chk (.*);

	initial begin
		#(TIMEOUT_NS);
		$display("watchdog expired before %0d frames were seen", NFRAMES);
		$display("** FAIL **");
		$finish;
	end

	initial begin
		repeat (4) @(negedge clk);
		rst = 1'b0;
		wb_cycle(1'b1, REG_HT, 8'(GEO_HT));
		wb_cycle(1'b1, REG_HD, 8'd4);
		wb_cycle(1'b1, REG_HP, 8'd6);
		wb_cycle(1'b1, REG_SYNCW, 8'h32);     // vw 3, hw 2
		wb_cycle(1'b1, REG_VT, 8'(GEO_VT));
		wb_cycle(1'b1, REG_VA, 8'(GEO_VA));
		wb_cycle(1'b1, REG_VD, 8'd3);
		wb_cycle(1'b1, REG_VP, 8'd4);
		wb_cycle(1'b1, REG_CTV, 8'(GEO_CTV));
		wb_cycle(1'b1, REG_DSH, 8'h12);
		wb_cycle(1'b1, REG_DSL, 8'h34);
		wb_cycle(1'b1, REG_CHAR, 8'h35);      // cth 3
		wb_cycle(1'b1, REG_COLOR, 8'he1);     // fg e, bg 1
		wb_cycle(1'b1, 6'd40, 8'h5a);         // above the register file
		for (int a = 0; a < 64; a++)
			wb_cycle(1'b0, 6'(a), 8'h00);
		run = 1'b1;
		wait (frames >= NFRAMES);
		repeat (8) @(negedge clk);
		$display("errors: bus %0d, sync %0d, video %0d, bus timeouts %0d",
		         err_bus, err_sync, err_video, bus_fail);
		if (err_bus + err_sync + err_video + bus_fail == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end
endmodule

//--- vdc_video.f
+incdir+.
vdc_pkg.sv
vdc_reg_if.sv
vdc_timing_if.sv
vdc_regs.sv
vdc_timing.sv
vdc_pixel.sv
vdc_video_top.sv
tb_vdc_check.sv
tb_vdc_video.sv

//--- Bender.yml
package:
  name: vdc_video

sources:
  - include_dirs:
      - .
    files:
      - vdc_pkg.sv
      - vdc_reg_if.sv
      - vdc_timing_if.sv
      - vdc_regs.sv
      - vdc_timing.sv
      - vdc_pixel.sv
      - vdc_video_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_vdc_check.sv
      - tb_vdc_video.sv
